// File: src/req_pkg.sv
// Request descriptor package with field types and the chunk parser states
package req_pkg;

  //////////////////////////////////////////////////////////////////////
  // Descriptor fields
  //////////////////////////////////////////////////////////////////////

  // Byte length of a request or of one chunk
  typedef logic [19:0] len_t;

  // Virtual byte address from the host side
  typedef logic [31:0] vaddr_t;

  // Process id, also part of the TLB tag
  typedef logic [5:0] pid_t;

  // Destination port selector
  typedef logic [3:0] dest_t;

  //////////////////////////////////////////////////////////////////////
  // Parser FSM
  //////////////////////////////////////////////////////////////////////

  // Idle waits for a descriptor
  // Parse forms one chunk, send offers it downstream
  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_parse = 2'd1,
    st_send  = 2'd2
  } parse_state_t;

endpackage

// File: src/xlat_pkg.sv
// Address translation package with page geometry and page number types
package xlat_pkg;

  //////////////////////////////////////////////////////////////////////
  // Page geometry
  //////////////////////////////////////////////////////////////////////

  // 4 KB pages
  localparam int PAGE_BITS = 12;
  localparam int PAGE_SIZE = 1 << PAGE_BITS;

  //////////////////////////////////////////////////////////////////////
  // Translation types
  //////////////////////////////////////////////////////////////////////

  // Virtual page number, upper bits of the virtual address
  typedef logic [19:0] vpn_t;

  // Physical page number as stored in the TLB
  typedef logic [19:0] ppn_t;

  // Physical byte address, PPN plus page offset
  typedef logic [31:0] paddr_t;

endpackage

// File: src/req_queue.sv
// Request queue, a synchronous FIFO holding whole request descriptors
`timescale 1ns/1ps

module req_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic             aclk,
  input  logic             aresetn,
  // Requester side
  input  logic             s_req_valid,
  output logic             s_req_ready,
  input  req_pkg::len_t    s_req_len,
  input  req_pkg::vaddr_t  s_req_vaddr,
  input  req_pkg::pid_t    s_req_pid,
  input  req_pkg::dest_t   s_req_dest,
  input  logic             s_req_ctl,
  input  logic             s_req_sync,
  input  logic             s_req_stream,
  input  logic             s_req_host,
  // Parser side
  output logic             q_req_valid,
  input  logic             q_req_ready,
  output req_pkg::len_t    q_req_len,
  output req_pkg::vaddr_t  q_req_vaddr,
  output req_pkg::pid_t    q_req_pid,
  output req_pkg::dest_t   q_req_dest,
  output logic             q_req_ctl,
  output logic             q_req_sync,
  output logic             q_req_stream,
  output logic             q_req_host
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  // Descriptor storage, one array per field
  req_pkg::len_t   mem_len    [QUEUE_DEPTH];
  req_pkg::vaddr_t mem_vaddr  [QUEUE_DEPTH];
  req_pkg::pid_t   mem_pid    [QUEUE_DEPTH];
  req_pkg::dest_t  mem_dest   [QUEUE_DEPTH];
  logic            mem_ctl    [QUEUE_DEPTH];
  logic            mem_sync   [QUEUE_DEPTH];
  logic            mem_stream [QUEUE_DEPTH];
  logic            mem_host   [QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_en;
  logic             rd_en;

  // Pointer step with wrap, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // Handshakes
  assign s_req_ready = (count != CNT_W'(QUEUE_DEPTH));
  assign q_req_valid = (count != '0);
  assign wr_en       = s_req_valid && s_req_ready;
  assign rd_en       = q_req_valid && q_req_ready;

  // Pointers and fill level
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en)
        wr_ptr <= ptr_inc(wr_ptr);
      if (rd_en)
        rd_ptr <= ptr_inc(rd_ptr);
      // Simultaneous push and pop keeps the level
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage write
  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem_len[wr_ptr]    <= s_req_len;
      mem_vaddr[wr_ptr]  <= s_req_vaddr;
      mem_pid[wr_ptr]    <= s_req_pid;
      mem_dest[wr_ptr]   <= s_req_dest;
      mem_ctl[wr_ptr]    <= s_req_ctl;
      mem_sync[wr_ptr]   <= s_req_sync;
      mem_stream[wr_ptr] <= s_req_stream;
      mem_host[wr_ptr]   <= s_req_host;
    end
  end

  // Head of queue, visible right after the write edge
  assign q_req_len    = mem_len[rd_ptr];
  assign q_req_vaddr  = mem_vaddr[rd_ptr];
  assign q_req_pid    = mem_pid[rd_ptr];
  assign q_req_dest   = mem_dest[rd_ptr];
  assign q_req_ctl    = mem_ctl[rd_ptr];
  assign q_req_sync   = mem_sync[rd_ptr];
  assign q_req_stream = mem_stream[rd_ptr];
  assign q_req_host   = mem_host[rd_ptr];

endmodule

// File: src/req_parser.sv
// Request parser FSM that cuts each descriptor into parse-unit chunks
`timescale 1ns/1ps

module req_parser #(
  parameter int PARSE_SIZE = 4096
) (
  input  logic             aclk,
  input  logic             aresetn,
  // From the queue
  input  logic             q_req_valid,
  output logic             q_req_ready,
  input  req_pkg::len_t    q_req_len,
  input  req_pkg::vaddr_t  q_req_vaddr,
  input  req_pkg::pid_t    q_req_pid,
  input  req_pkg::dest_t   q_req_dest,
  input  logic             q_req_ctl,
  input  logic             q_req_sync,
  input  logic             q_req_stream,
  input  logic             q_req_host,
  // Chunks to the TLB
  output logic             c_req_valid,
  input  logic             c_req_ready,
  output req_pkg::len_t    c_req_len,
  output req_pkg::vaddr_t  c_req_vaddr,
  output req_pkg::pid_t    c_req_pid,
  output req_pkg::dest_t   c_req_dest,
  output logic             c_req_ctl,
  output logic             c_req_sync,
  output logic             c_req_stream,
  output logic             c_req_host
);

  // Parse unit in the widths of length and address
  localparam req_pkg::len_t   PARSE_LEN  = req_pkg::len_t'(PARSE_SIZE);
  localparam req_pkg::vaddr_t PARSE_STEP = req_pkg::vaddr_t'(PARSE_SIZE);

  req_pkg::parse_state_t state_q, state_d;

  // Remaining request, fields shared by all chunks
  req_pkg::len_t   len_q, len_d;
  req_pkg::vaddr_t vaddr_q, vaddr_d;
  req_pkg::pid_t   pid_q, pid_d;
  req_pkg::dest_t  dest_q, dest_d;
  logic            ctl_q, ctl_d;
  logic            sync_q, sync_d;
  logic            stream_q, stream_d;
  logic            host_q, host_d;

  // Chunk being offered
  req_pkg::len_t   plen_q, plen_d;
  req_pkg::vaddr_t pvaddr_q, pvaddr_d;
  logic            pctl_q, pctl_d;

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn)
      state_q <= req_pkg::st_idle;
    else
      state_q <= state_d;
  end

  always_ff @(posedge aclk) begin
    len_q    <= len_d;
    vaddr_q  <= vaddr_d;
    pid_q    <= pid_d;
    dest_q   <= dest_d;
    ctl_q    <= ctl_d;
    sync_q   <= sync_d;
    stream_q <= stream_d;
    host_q   <= host_d;
    plen_q   <= plen_d;
    pvaddr_q <= pvaddr_d;
    pctl_q   <= pctl_d;
  end

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      req_pkg::st_idle:
        if (q_req_valid)
          state_d = req_pkg::st_parse;
      // Always a single cycle
      req_pkg::st_parse:
        state_d = req_pkg::st_send;
      // Loop back while bytes remain
      req_pkg::st_send:
        if (c_req_ready)
          state_d = (len_q != '0) ? req_pkg::st_parse : req_pkg::st_idle;
      default:
        state_d = req_pkg::st_idle;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    len_d    = len_q;
    vaddr_d  = vaddr_q;
    pid_d    = pid_q;
    dest_d   = dest_q;
    ctl_d    = ctl_q;
    sync_d   = sync_q;
    stream_d = stream_q;
    host_d   = host_q;
    plen_d   = plen_q;
    pvaddr_d = pvaddr_q;
    pctl_d   = pctl_q;

    case (state_q)
      // Latch a new descriptor
      req_pkg::st_idle:
        if (q_req_valid) begin
          len_d    = q_req_len;
          vaddr_d  = q_req_vaddr;
          pid_d    = q_req_pid;
          dest_d   = q_req_dest;
          ctl_d    = q_req_ctl;
          sync_d   = q_req_sync;
          stream_d = q_req_stream;
          host_d   = q_req_host;
        end
      req_pkg::st_parse: begin
        pvaddr_d = vaddr_q;
        if (len_q > PARSE_LEN) begin
          // Full unit, not the last chunk
          plen_d  = PARSE_LEN;
          pctl_d  = 1'b0;
          len_d   = len_q - PARSE_LEN;
          vaddr_d = vaddr_q + PARSE_STEP;
        end else begin
          // Tail, also covers a zero length request
          plen_d = len_q;
          pctl_d = ctl_q;
          len_d  = '0;
        end
      end
      default: ;
    endcase
  end

  // Handshakes follow the state
  assign q_req_ready = (state_q == req_pkg::st_idle);
  assign c_req_valid = (state_q == req_pkg::st_send);

  assign c_req_len    = plen_q;
  assign c_req_vaddr  = pvaddr_q;
  assign c_req_ctl    = pctl_q;
  assign c_req_pid    = pid_q;
  assign c_req_dest   = dest_q;
  assign c_req_sync   = sync_q;
  assign c_req_stream = stream_q;
  assign c_req_host   = host_q;

endmodule

// File: src/tlb_lookup.sv
// Direct-mapped TLB with a config write port and a registered chunk lookup
`timescale 1ns/1ps

module tlb_lookup #(
  parameter int TLB_ENTRIES = 16
) (
  input  logic              aclk,
  input  logic              aresetn,
  // Table programming, always accepted
  input  logic              cfg_valid,
  input  req_pkg::pid_t     cfg_pid,
  input  xlat_pkg::vpn_t    cfg_vpn,
  input  xlat_pkg::ppn_t    cfg_ppn,
  // Chunks from the parser
  input  logic              c_req_valid,
  output logic              c_req_ready,
  input  req_pkg::len_t     c_req_len,
  input  req_pkg::vaddr_t   c_req_vaddr,
  input  req_pkg::pid_t     c_req_pid,
  input  req_pkg::dest_t    c_req_dest,
  input  logic              c_req_ctl,
  input  logic              c_req_sync,
  input  logic              c_req_stream,
  input  logic              c_req_host,
  // Translated chunks
  output logic              m_req_valid,
  input  logic              m_req_ready,
  output req_pkg::len_t     m_req_len,
  output xlat_pkg::paddr_t  m_req_paddr,
  output req_pkg::pid_t     m_req_pid,
  output req_pkg::dest_t    m_req_dest,
  output logic              m_req_ctl,
  output logic              m_req_sync,
  output logic              m_req_stream,
  output logic              m_req_host,
  output logic              m_req_miss
);

  // Entry count is a power of two
  localparam int IDX_W = $clog2(TLB_ENTRIES);
  localparam int VA_W  = $bits(req_pkg::vaddr_t);

  typedef logic [IDX_W-1:0] tlb_idx_t;

  // Table
  logic [TLB_ENTRIES-1:0] tlb_valid;
  req_pkg::pid_t          tlb_pid [TLB_ENTRIES];
  xlat_pkg::vpn_t         tlb_vpn [TLB_ENTRIES];
  xlat_pkg::ppn_t         tlb_ppn [TLB_ENTRIES];

  tlb_idx_t         wr_idx;
  tlb_idx_t         rd_idx;
  xlat_pkg::vpn_t   c_vpn;
  logic             hit;
  xlat_pkg::paddr_t hit_paddr;
  logic             in_fire;

  //////////////////////////////////////////////////////////////////////
  // Table write
  //////////////////////////////////////////////////////////////////////

  // Index from the low VPN bits
  assign wr_idx = cfg_vpn[IDX_W-1:0];

  always_ff @(posedge aclk) begin
    if (!aresetn)
      tlb_valid <= '0;
    else if (cfg_valid)
      tlb_valid[wr_idx] <= 1'b1;
  end

  // A rewrite of the same index replaces the old mapping
  always_ff @(posedge aclk) begin
    if (cfg_valid) begin
      tlb_pid[wr_idx] <= cfg_pid;
      tlb_vpn[wr_idx] <= cfg_vpn;
      tlb_ppn[wr_idx] <= cfg_ppn;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////////////////////////

  // Only the chunk start address is translated
  assign c_vpn  = c_req_vaddr[VA_W-1:xlat_pkg::PAGE_BITS];
  assign rd_idx = c_vpn[IDX_W-1:0];

  // Tag is pid plus full VPN
  assign hit = tlb_valid[rd_idx] &&
               (tlb_pid[rd_idx] == c_req_pid) &&
               (tlb_vpn[rd_idx] == c_vpn);

  // PPN followed by untouched page offset
  assign hit_paddr = {tlb_ppn[rd_idx], c_req_vaddr[xlat_pkg::PAGE_BITS-1:0]};

  //////////////////////////////////////////////////////////////////////
  // Output stage
  //////////////////////////////////////////////////////////////////////

  // Accept when empty or draining
  assign c_req_ready = !m_req_valid || m_req_ready;
  assign in_fire     = c_req_valid && c_req_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn)
      m_req_valid <= 1'b0;
    else if (in_fire)
      m_req_valid <= 1'b1;
    else if (m_req_ready)
      m_req_valid <= 1'b0;
  end

  always_ff @(posedge aclk) begin
    if (in_fire) begin
      m_req_len    <= c_req_len;
      m_req_pid    <= c_req_pid;
      m_req_dest   <= c_req_dest;
      m_req_ctl    <= c_req_ctl;
      m_req_sync   <= c_req_sync;
      m_req_stream <= c_req_stream;
      m_req_host   <= c_req_host;
      // Miss gives a zero address
      m_req_paddr  <= hit ? hit_paddr : '0;
      m_req_miss   <= !hit;
    end
  end

endmodule

// File: src/xlat_top.sv
// Translation front end top, chaining request queue, parser and TLB lookup
`timescale 1ns/1ps

module xlat_top #(
  parameter int PARSE_SIZE  = xlat_pkg::PAGE_SIZE,
  parameter int QUEUE_DEPTH = 4,
  parameter int TLB_ENTRIES = 16
) (
  input  logic              aclk,
  input  logic              aresetn,
  // TLB programming
  input  logic              cfg_valid,
  input  req_pkg::pid_t     cfg_pid,
  input  xlat_pkg::vpn_t    cfg_vpn,
  input  xlat_pkg::ppn_t    cfg_ppn,
  // Host requests
  input  logic              s_req_valid,
  output logic              s_req_ready,
  input  req_pkg::len_t     s_req_len,
  input  req_pkg::vaddr_t   s_req_vaddr,
  input  req_pkg::pid_t     s_req_pid,
  input  req_pkg::dest_t    s_req_dest,
  input  logic              s_req_ctl,
  input  logic              s_req_sync,
  input  logic              s_req_stream,
  input  logic              s_req_host,
  // Translated chunks
  output logic              m_req_valid,
  input  logic              m_req_ready,
  output req_pkg::len_t     m_req_len,
  output xlat_pkg::paddr_t  m_req_paddr,
  output req_pkg::pid_t     m_req_pid,
  output req_pkg::dest_t    m_req_dest,
  output logic              m_req_ctl,
  output logic              m_req_sync,
  output logic              m_req_stream,
  output logic              m_req_host,
  output logic              m_req_miss
);

  // Queue to parser
  logic q_req_valid, q_req_ready;
  req_pkg::len_t   q_req_len;
  req_pkg::vaddr_t q_req_vaddr;
  req_pkg::pid_t   q_req_pid;
  req_pkg::dest_t  q_req_dest;
  logic q_req_ctl, q_req_sync, q_req_stream, q_req_host;

  // Parser to TLB
  logic c_req_valid, c_req_ready;
  req_pkg::len_t   c_req_len;
  req_pkg::vaddr_t c_req_vaddr;
  req_pkg::pid_t   c_req_pid;
  req_pkg::dest_t  c_req_dest;
  logic c_req_ctl, c_req_sync, c_req_stream, c_req_host;

  // Descriptor buffer
  req_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_req_queue (
    .aclk(aclk), .aresetn(aresetn),
    .s_req_valid(s_req_valid), .s_req_ready(s_req_ready),
    .s_req_len(s_req_len), .s_req_vaddr(s_req_vaddr),
    .s_req_pid(s_req_pid), .s_req_dest(s_req_dest),
    .s_req_ctl(s_req_ctl), .s_req_sync(s_req_sync),
    .s_req_stream(s_req_stream), .s_req_host(s_req_host),
    .q_req_valid(q_req_valid), .q_req_ready(q_req_ready),
    .q_req_len(q_req_len), .q_req_vaddr(q_req_vaddr),
    .q_req_pid(q_req_pid), .q_req_dest(q_req_dest),
    .q_req_ctl(q_req_ctl), .q_req_sync(q_req_sync),
    .q_req_stream(q_req_stream), .q_req_host(q_req_host)
  );

  // Chunking
  req_parser #(.PARSE_SIZE(PARSE_SIZE)) i_req_parser (
    .aclk(aclk), .aresetn(aresetn),
    .q_req_valid(q_req_valid), .q_req_ready(q_req_ready),
    .q_req_len(q_req_len), .q_req_vaddr(q_req_vaddr),
    .q_req_pid(q_req_pid), .q_req_dest(q_req_dest),
    .q_req_ctl(q_req_ctl), .q_req_sync(q_req_sync),
    .q_req_stream(q_req_stream), .q_req_host(q_req_host),
    .c_req_valid(c_req_valid), .c_req_ready(c_req_ready),
    .c_req_len(c_req_len), .c_req_vaddr(c_req_vaddr),
    .c_req_pid(c_req_pid), .c_req_dest(c_req_dest),
    .c_req_ctl(c_req_ctl), .c_req_sync(c_req_sync),
    .c_req_stream(c_req_stream), .c_req_host(c_req_host)
  );

  // Translation
  tlb_lookup #(.TLB_ENTRIES(TLB_ENTRIES)) i_tlb_lookup (
    .aclk(aclk), .aresetn(aresetn),
    .cfg_valid(cfg_valid), .cfg_pid(cfg_pid),
    .cfg_vpn(cfg_vpn), .cfg_ppn(cfg_ppn),
    .c_req_valid(c_req_valid), .c_req_ready(c_req_ready),
    .c_req_len(c_req_len), .c_req_vaddr(c_req_vaddr),
    .c_req_pid(c_req_pid), .c_req_dest(c_req_dest),
    .c_req_ctl(c_req_ctl), .c_req_sync(c_req_sync),
    .c_req_stream(c_req_stream), .c_req_host(c_req_host),
    .m_req_valid(m_req_valid), .m_req_ready(m_req_ready),
    .m_req_len(m_req_len), .m_req_paddr(m_req_paddr),
    .m_req_pid(m_req_pid), .m_req_dest(m_req_dest),
    .m_req_ctl(m_req_ctl), .m_req_sync(m_req_sync),
    .m_req_stream(m_req_stream), .m_req_host(m_req_host),
    .m_req_miss(m_req_miss)
  );

endmodule

// File: verification/tb_xlat.sv
// Translation front end testbench driven from a tests file of stimulus and expected chunks
`timescale 1ns/1ps

module tb_xlat;

  // W or R line of the tests file
  typedef struct packed {
    logic [7:0]       kind;
    req_pkg::len_t    len;
    req_pkg::vaddr_t  vaddr;
    req_pkg::pid_t    pid;
    req_pkg::dest_t   dest;
    logic             ctl;
    logic             sync;
    logic             stream;
    logic             host;
    xlat_pkg::vpn_t   vpn;
    xlat_pkg::ppn_t   ppn;
    logic [31:0]      exp_before;
  } op_t;

  // One expected output chunk from an E line
  typedef struct packed {
    req_pkg::len_t    len;
    xlat_pkg::paddr_t paddr;
    logic             miss;
    logic             ctl;
    req_pkg::pid_t    pid;
    req_pkg::dest_t   dest;
  } chunk_t;

  logic             aclk;
  logic             aresetn;
  logic             cfg_valid;
  req_pkg::pid_t    cfg_pid;
  xlat_pkg::vpn_t   cfg_vpn;
  xlat_pkg::ppn_t   cfg_ppn;
  logic             s_req_valid;
  logic             s_req_ready;
  req_pkg::len_t    s_req_len;
  req_pkg::vaddr_t  s_req_vaddr;
  req_pkg::pid_t    s_req_pid;
  req_pkg::dest_t   s_req_dest;
  logic             s_req_ctl;
  logic             s_req_sync;
  logic             s_req_stream;
  logic             s_req_host;
  logic             m_req_valid;
  logic             m_req_ready;
  req_pkg::len_t    m_req_len;
  xlat_pkg::paddr_t m_req_paddr;
  req_pkg::pid_t    m_req_pid;
  req_pkg::dest_t   m_req_dest;
  logic             m_req_ctl;
  logic             m_req_sync;
  logic             m_req_stream;
  logic             m_req_host;
  logic             m_req_miss;

  op_t    ops[$];
  chunk_t expected[$];
  // Sync, stream and host per expected chunk, taken from its request
  logic [2:0] flags_expected[$];
  int     total_chunks;
  int     matched;
  int     cycles;
  int     cycle_limit;
  integer seed;
  bit     loaded;
  bit     running;

  xlat_top i_dut (
    .aclk(aclk), .aresetn(aresetn),
    .cfg_valid(cfg_valid), .cfg_pid(cfg_pid),
    .cfg_vpn(cfg_vpn), .cfg_ppn(cfg_ppn),
    .s_req_valid(s_req_valid), .s_req_ready(s_req_ready),
    .s_req_len(s_req_len), .s_req_vaddr(s_req_vaddr),
    .s_req_pid(s_req_pid), .s_req_dest(s_req_dest),
    .s_req_ctl(s_req_ctl), .s_req_sync(s_req_sync),
    .s_req_stream(s_req_stream), .s_req_host(s_req_host),
    .m_req_valid(m_req_valid), .m_req_ready(m_req_ready),
    .m_req_len(m_req_len), .m_req_paddr(m_req_paddr),
    .m_req_pid(m_req_pid), .m_req_dest(m_req_dest),
    .m_req_ctl(m_req_ctl), .m_req_sync(m_req_sync),
    .m_req_stream(m_req_stream), .m_req_host(m_req_host),
    .m_req_miss(m_req_miss)
  );

  // 100 ns clock
  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  //////////////////////////////////////////////////////////////////////
  // Error helpers
  //////////////////////////////////////////////////////////////////////

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    stop_with_error($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, want));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests file
  //////////////////////////////////////////////////////////////////////

  task automatic load_tests();
    integer      fd;
    integer      rc;
    string       line;
    logic [31:0] v[8];
    op_t         op;
    chunk_t      ch;
    int          n_chunks;
    fd = $fopen("verification/xlat_tests.txt", "r");
    assert (fd != 0) else stop_with_error("Cannot open verification/xlat_tests.txt");
    while (!$feof(fd)) begin
      line = "";
      rc = $fgets(line, fd);
      // Comments and blank lines
      if (rc == 0 || line.len() < 2 || line[0] == "#")
        continue;
      op = '0;
      ch = '0;
      case (line[0])
        "W": begin
          rc = $sscanf(line, "W %h %h %h", v[0], v[1], v[2]);
          assert (rc == 3) else stop_with_error($sformatf("Bad TLB write line: %s", line));
          op.kind = "W";
          op.pid  = req_pkg::pid_t'(v[0]);
          op.vpn  = xlat_pkg::vpn_t'(v[1]);
          op.ppn  = xlat_pkg::ppn_t'(v[2]);
          // Chunks that must drain before the table changes
          op.exp_before = 32'(expected.size());
          ops.push_back(op);
        end
        "R": begin
          rc = $sscanf(line, "R %h %h %h %h %h %h %h %h",
                       v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
          assert (rc == 8) else stop_with_error($sformatf("Bad request line: %s", line));
          op.kind   = "R";
          op.len    = req_pkg::len_t'(v[0]);
          op.vaddr  = req_pkg::vaddr_t'(v[1]);
          op.pid    = req_pkg::pid_t'(v[2]);
          op.dest   = req_pkg::dest_t'(v[3]);
          op.ctl    = v[4][0];
          op.sync   = v[5][0];
          op.stream = v[6][0];
          op.host   = v[7][0];
          ops.push_back(op);
          // One chunk per started page, and one for a zero length
          n_chunks = (op.len == '0) ? 1
                   : (int'(op.len) + xlat_pkg::PAGE_SIZE - 1) / xlat_pkg::PAGE_SIZE;
          repeat (n_chunks)
            flags_expected.push_back({op.sync, op.stream, op.host});
        end
        "E": begin
          rc = $sscanf(line, "E %h %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4], v[5]);
          assert (rc == 6) else stop_with_error($sformatf("Bad expected line: %s", line));
          ch.len   = req_pkg::len_t'(v[0]);
          ch.paddr = xlat_pkg::paddr_t'(v[1]);
          ch.miss  = v[2][0];
          ch.ctl   = v[3][0];
          ch.pid   = req_pkg::pid_t'(v[4]);
          ch.dest  = req_pkg::dest_t'(v[5]);
          expected.push_back(ch);
        end
        default:
          stop_with_error($sformatf("Unknown line kind in the tests file: %s", line));
      endcase
    end
    $fclose(fd);
    assert (flags_expected.size() == expected.size())
      else stop_with_error("The tests file has a different count of request chunks and E lines");
    total_chunks = expected.size();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Driver and monitor tasks
  //////////////////////////////////////////////////////////////////////

  // TLB write with cfg_valid high for one cycle
  task automatic send_config(input op_t op);
    while (matched < int'(op.exp_before)) begin
      @(posedge aclk);
      #1;
    end
    cfg_pid   = op.pid;
    cfg_vpn   = op.vpn;
    cfg_ppn   = op.ppn;
    cfg_valid = 1'b1;
    @(posedge aclk);
    #1;
    cfg_valid = 1'b0;
  endtask

  // s_req_ready only moves on the edge and is sampled here between edges
  task automatic send_request(input op_t op);
    s_req_len    = op.len;
    s_req_vaddr  = op.vaddr;
    s_req_pid    = op.pid;
    s_req_dest   = op.dest;
    s_req_ctl    = op.ctl;
    s_req_sync   = op.sync;
    s_req_stream = op.stream;
    s_req_host   = op.host;
    s_req_valid  = 1'b1;
    while (!s_req_ready) begin
      @(posedge aclk);
      #1;
    end
    @(posedge aclk);
    #1;
    s_req_valid = 1'b0;
  endtask

  task automatic check_chunk();
    chunk_t     e;
    logic [2:0] f;
    assert (expected.size() != 0)
      else stop_with_error("An output chunk appeared after all expected chunks were seen");
    e = expected.pop_front();
    f = flags_expected.pop_front();
    assert (m_req_len == e.len)
      else report_mismatch("m_req_len", 32'(m_req_len), 32'(e.len));
    assert (m_req_paddr == e.paddr)
      else report_mismatch("m_req_paddr", 32'(m_req_paddr), 32'(e.paddr));
    assert (m_req_miss == e.miss)
      else report_mismatch("m_req_miss", 32'(m_req_miss), 32'(e.miss));
    assert (m_req_ctl == e.ctl)
      else report_mismatch("m_req_ctl", 32'(m_req_ctl), 32'(e.ctl));
    assert (m_req_pid == e.pid)
      else report_mismatch("m_req_pid", 32'(m_req_pid), 32'(e.pid));
    assert (m_req_dest == e.dest)
      else report_mismatch("m_req_dest", 32'(m_req_dest), 32'(e.dest));
    assert (m_req_sync == f[2])
      else report_mismatch("m_req_sync", 32'(m_req_sync), 32'(f[2]));
    assert (m_req_stream == f[1])
      else report_mismatch("m_req_stream", 32'(m_req_stream), 32'(f[1]));
    assert (m_req_host == f[0])
      else report_mismatch("m_req_host", 32'(m_req_host), 32'(f[0]));
    matched = matched + 1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Processes
  //////////////////////////////////////////////////////////////////////

  // Reset and then W and R lines in file order
  initial begin
    seed         = 50;
    matched      = 0;
    cycles       = 0;
    cycle_limit  = 0;
    total_chunks = 0;
    loaded       = 1'b0;
    running      = 1'b0;
    aresetn      = 1'b0;
    cfg_valid    = 1'b0;
    cfg_pid      = '0;
    cfg_vpn      = '0;
    cfg_ppn      = '0;
    s_req_valid  = 1'b0;
    s_req_len    = '0;
    s_req_vaddr  = '0;
    s_req_pid    = '0;
    s_req_dest   = '0;
    s_req_ctl    = 1'b0;
    s_req_sync   = 1'b0;
    s_req_stream = 1'b0;
    s_req_host   = 1'b0;
    m_req_ready  = 1'b0;
    load_tests();
    loaded = 1'b1;
    repeat (10) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    running = 1'b1;
    foreach (ops[i]) begin
      if (ops[i].kind == "W")
        send_config(ops[i]);
      else
        send_request(ops[i]);
    end
    while (matched < total_chunks) begin
      @(posedge aclk);
      #1;
    end
    // A few idle cycles so a duplicated chunk still shows up
    repeat (10) @(posedge aclk);
    $display("Test OK");
    $finish;
  end

  // Random back-pressure with the output sampled at the falling edge
  initial begin
    wait (running);
    forever begin
      @(posedge aclk);
      #1;
      m_req_ready = (($random(seed) & 3) != 0);
      @(negedge aclk);
      if (m_req_valid && m_req_ready)
        check_chunk();
    end
  end

  // Cycle budget of 20 per expected chunk plus 100
  initial begin
    wait (loaded);
    cycle_limit = 20 * total_chunks + 100;
    forever begin
      @(posedge aclk);
      cycles = cycles + 1;
      assert (cycles < cycle_limit)
        else stop_with_error($sformatf("Timeout: the run did not finish in %0d cycles",
                                       cycle_limit));
    end
  end

endmodule

// File: src.f
src/req_pkg.sv
src/xlat_pkg.sv
src/req_queue.sv
src/req_parser.sv
src/tlb_lookup.sv
src/xlat_top.sv
verification/tb_xlat.sv

// File: run.sh
#!/bin/sh
# Builds the translation front end testbench with Verilator and runs it.
# The run passes only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --assert --top-module tb_xlat -f src.f > build.log 2>&1 \
  && ./obj_dir/Vtb_xlat > sim.log 2>&1

grep -qsx "Test OK" sim.log \
  && echo "Simulation passed, see sim.log" \
  && exit 0 \
  || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// File: verification/xlat_tests.txt
# Columns, all hex: W pid vpn ppn | R len vaddr pid dest ctl sync stream host
# E len paddr miss ctl pid dest, one expected output chunk, in output order
#
# TLB setup, index is the low four VPN bits
W 01 00010 abcde
W 01 00011 12345
W 01 00012 22222
W 01 00013 33333
W 02 00024 44444
#
# Short request, one chunk with its own length and ctl
R 00100 00010123 01 3 1 0 1 0
E 00100 abcde123 0 1 01 3
#
# Three and a half pages, four chunks, ctl on the last only
R 03800 00010200 01 5 1 1 0 1
E 01000 abcde200 0 0 01 5
E 01000 12345200 0 0 01 5
E 01000 22222200 0 0 01 5
E 00800 33333200 0 1 01 5
#
# Exactly one page stays one chunk, ctl kept at 0
R 01000 00024000 02 7 0 0 0 1
E 01000 44444000 0 0 02 7
#
# Unprogrammed VPN
R 00040 00015abc 01 1 1 0 0 0
E 00040 00000000 1 1 01 1
#
# Matching VPN under another pid
R 00080 00024010 03 2 1 1 1 1
E 00080 00000000 1 1 03 2
#
# Same index as VPN 10 but a different tag
R 00010 00020008 01 0 1 0 1 1
E 00010 00000000 1 1 01 0
#
# Zero length gives one empty chunk
R 00000 00011ff0 01 4 1 0 0 1
E 00000 12345ff0 0 1 01 4
#
# Rewrite index 0 and use the new mapping
W 01 00010 55555
R 00020 00010040 01 6 1 0 0 0
E 00020 55555040 0 1 01 6
#
# Rewrite index 0 for another pid, the old mapping is gone
W 05 00030 0ff00
R 00020 00010040 01 6 1 0 0 0
E 00020 00000000 1 1 01 6
R 00100 00030f00 05 d 1 1 0 0
E 00100 0ff00f00 0 1 05 d
#
# Back to back burst, more requests than queue entries
R 02000 00011000 01 8 1 0 1 0
R 01001 00012fff 01 9 0 1 1 0
R 00004 00024ffc 02 a 1 0 0 1
R 00c00 00013400 01 b 1 1 1 1
R 00001 00016000 01 c 0 0 1 0
E 01000 12345000 0 0 01 8
E 01000 22222000 0 1 01 8
E 01000 22222fff 0 0 01 9
E 00001 33333fff 0 0 01 9
E 00004 44444ffc 0 1 02 a
E 00c00 33333400 0 1 01 b
E 00001 00000000 1 0 01 c
